//--- hw/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// raw hit timestamp width
`define HIST_TS_BITS 10

// bin index width, top bits of the timestamp
`define HIST_BIN_BITS 4

// entries per histogram RAM
`define HIST_NUM_BINS (1 << `HIST_BIN_BITS)

// per-bin counter width
`define HIST_COUNT_BITS 8

// counters stop here instead of wrapping
`define HIST_COUNT_MAX ((1 << `HIST_COUNT_BITS) - 1)

`endif

//--- hw/histDataPkg.sv
`include "hist_defs.svh"

package histDataPkg;

    // raw arrival time of one photon hit
    typedef logic [`HIST_TS_BITS-1:0] timeStamp;

    // histogram bin address
    typedef logic [`HIST_BIN_BITS-1:0] binIdx;

    // hits accumulated in one bin
    typedef logic [`HIST_COUNT_BITS-1:0] binCount;

    // relative delay between channels, one extra bit for sign
    typedef logic signed [`HIST_BIN_BITS:0] binDelta;

    // location and height of a histogram maximum
    typedef struct packed {
        binIdx   bin;
        binCount count;
    } peakInfo;

    // what the combiner reports per frame
    typedef struct packed {
        logic    winner; // 1 when channel 1 has the taller peak
        peakInfo peak;   // peak of the winning channel
        binDelta delta;  // chan1 bin minus chan0 bin
    } frameResult;

endpackage

//--- hw/histCtrlPkg.sv
package histCtrlPkg;

    // builder sequencing, one frame walks through all of these
    typedef enum logic [2:0] {
        idle,
        clear,      // zero all bins
        accumulate, // count hits
        drain,      // let the last pending write land
        search,     // scan bins for the maximum
        report      // present the peak for one cycle
    } builderState;

    // summary flags seen from outside
    typedef struct packed {
        logic busy;      // clearing or searching
        logic accepting; // hits are being counted
    } chanStatus;

endpackage

//--- hw/histRam.sv
`include "hist_defs.svh"

module histRam (
    input  logic                clk,
    input  logic                rdEn,
    input  histDataPkg::binIdx   rdAddr,
    output histDataPkg::binCount rdData,
    input  logic                wrEn,
    input  histDataPkg::binIdx   wrAddr,
    input  histDataPkg::binCount wrData
);

    histDataPkg::binCount mem [`HIST_NUM_BINS];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, same-address write in the same cycle is not visible yet
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- hw/histBuilder.sv
`include "hist_defs.svh"

module histBuilder (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  logic                  hit,
    input  logic                  frameEnd,
    input  histDataPkg::timeStamp ts,
    output logic                  busy,
    output logic                  accepting,
    output logic                  peakValid,
    output histDataPkg::peakInfo  peak
);

    histCtrlPkg::builderState state;
    histCtrlPkg::builderState nextState;

    histDataPkg::binIdx hitBin;
    histDataPkg::binIdx addrCnt;    // clear and search address
    histDataPkg::binIdx pendBin;    // bin of the update in flight
    histDataPkg::binIdx lastBin;    // bin written last cycle
    histDataPkg::binIdx cmpBin;     // address of the count now on rdData
    histDataPkg::binIdx maxBin;

    histDataPkg::binCount rdData;
    histDataPkg::binCount lastData; // value written last cycle
    histDataPkg::binCount baseCount;
    histDataPkg::binCount incCount;
    histDataPkg::binCount maxCount;

    logic acceptHit;
    logic pendValid;
    logic lastValid;
    logic cmpValid;
    logic srchDone;

    logic                 ramRdEn;
    histDataPkg::binIdx   ramRdAddr;
    logic                 ramWrEn;
    histDataPkg::binIdx   ramWrAddr;
    histDataPkg::binCount ramWrData;

    assign hitBin    = ts[`HIST_TS_BITS-1 -: `HIST_BIN_BITS];
    assign acceptHit = (state == histCtrlPkg::accumulate) && hit;

    // next state, start wins from anywhere
    always_comb begin
        nextState = state;
        case (state)
            histCtrlPkg::idle: begin
                nextState = histCtrlPkg::idle;
            end
            histCtrlPkg::clear: begin
                if (addrCnt == '1) begin
                    nextState = histCtrlPkg::accumulate;
                end
            end
            histCtrlPkg::accumulate: begin
                if (frameEnd) begin
                    nextState = histCtrlPkg::drain;
                end
            end
            histCtrlPkg::drain: begin
                nextState = histCtrlPkg::search;
            end
            histCtrlPkg::search: begin
                // last count compared this cycle
                if (cmpValid && cmpBin == '1) begin
                    nextState = histCtrlPkg::report;
                end
            end
            histCtrlPkg::report: begin
                nextState = histCtrlPkg::idle;
            end
            default: begin
                nextState = histCtrlPkg::idle;
            end
        endcase
        if (start) begin
            nextState = histCtrlPkg::clear;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= histCtrlPkg::idle;
            addrCnt   <= '0;
            srchDone  <= 1'b0;
            pendValid <= 1'b0;
            lastValid <= 1'b0;
            cmpValid  <= 1'b0;
        end else begin
            state     <= nextState;
            pendValid <= acceptHit;
            lastValid <= ramWrEn;
            cmpValid  <= ramRdEn && (state == histCtrlPkg::search);

            if (start || state == histCtrlPkg::drain) begin
                addrCnt <= '0;
            end else if (state == histCtrlPkg::clear ||
                         (state == histCtrlPkg::search && !srchDone)) begin
                addrCnt <= addrCnt + 1'b1; // wraps to 0 after bin 15
            end

            if (start || state == histCtrlPkg::drain) begin
                srchDone <= 1'b0;
            end else if (state == histCtrlPkg::search && addrCnt == '1) begin
                srchDone <= 1'b1; // all reads issued
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        pendBin  <= hitBin;
        lastBin  <= ramWrAddr;
        lastData <= ramWrData;
        cmpBin   <= addrCnt;   // follows the read by one cycle

        if (state == histCtrlPkg::drain) begin
            maxCount <= '0;
            maxBin   <= '0;
        end else if (cmpValid && rdData > maxCount) begin
            maxCount <= rdData; // strictly greater, so ties keep the lower bin
            maxBin   <= cmpBin;
        end
    end

    // RAM output is stale if the same bin was written one cycle earlier
    assign baseCount = (lastValid && lastBin == pendBin) ? lastData : rdData;
    assign incCount  = (baseCount == `HIST_COUNT_MAX) ? baseCount : baseCount + 1'b1;

    assign ramRdEn   = acceptHit || (state == histCtrlPkg::search && !srchDone);
    assign ramRdAddr = (state == histCtrlPkg::search) ? addrCnt : hitBin;

    // clear owns the write port, otherwise the pending update
    assign ramWrEn   = (state == histCtrlPkg::clear) || pendValid;
    assign ramWrAddr = (state == histCtrlPkg::clear) ? addrCnt : pendBin;
    assign ramWrData = (state == histCtrlPkg::clear) ? '0 : incCount;

    histRam ramInst (
        .clk    (clk),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (rdData),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData)
    );

    assign busy       = (state != histCtrlPkg::idle) && (state != histCtrlPkg::accumulate);
    assign accepting  = (state == histCtrlPkg::accumulate);
    assign peakValid  = (state == histCtrlPkg::report);
    assign peak.bin   = maxBin;
    assign peak.count = maxCount;

endmodule

//--- hw/peakCombiner.sv
module peakCombiner (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    peakValid0,
    input  logic                    peakValid1,
    input  histDataPkg::peakInfo    peak0,
    input  histDataPkg::peakInfo    peak1,
    output logic                    resultValid,
    output histDataPkg::frameResult result
);

    logic have0;
    logic have1;
    logic both;

    histDataPkg::peakInfo    held0;
    histDataPkg::peakInfo    held1;
    histDataPkg::peakInfo    cur0;
    histDataPkg::peakInfo    cur1;
    histDataPkg::frameResult nextResult;

    // a peak arriving this cycle counts as already latched
    assign cur0 = peakValid0 ? peak0 : held0;
    assign cur1 = peakValid1 ? peak1 : held1;
    assign both = (have0 | peakValid0) & (have1 | peakValid1);

    always_comb begin
        nextResult.winner = cur1.count > cur0.count; // chan0 keeps ties
        nextResult.peak   = nextResult.winner ? cur1 : cur0;
        nextResult.delta  = histDataPkg::binDelta'({1'b0, cur1.bin}) -
                            histDataPkg::binDelta'({1'b0, cur0.bin});
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            have0       <= 1'b0;
            have1       <= 1'b0;
            resultValid <= 1'b0;
        end else if (both) begin
            have0       <= 1'b0;
            have1       <= 1'b0;
            resultValid <= 1'b1;
        end else begin
            have0       <= have0 | peakValid0; // sticky until both seen
            have1       <= have1 | peakValid1;
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (peakValid0) held0 <= peak0;
        if (peakValid1) held1 <= peak1;
        if (both) result <= nextResult;
    end

endmodule

//--- hw/tofHistTop.sv
module tofHistTop (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    start,
    input  logic                    frameEnd,
    input  logic                    hit0,
    input  logic                    hit1,
    input  histDataPkg::timeStamp   ts0,
    input  histDataPkg::timeStamp   ts1,
    output logic                    resultValid,
    output histDataPkg::frameResult result,
    output histCtrlPkg::chanStatus  status
);

    logic busy0;
    logic busy1;
    logic accepting0;
    logic accepting1;
    logic peakValid0;
    logic peakValid1;

    histDataPkg::peakInfo peak0;
    histDataPkg::peakInfo peak1;

    // both channels see the same frame strobes, so they finish together
    histBuilder chan0Inst (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .hit       (hit0),
        .frameEnd  (frameEnd),
        .ts        (ts0),
        .busy      (busy0),
        .accepting (accepting0),
        .peakValid (peakValid0),
        .peak      (peak0)
    );

    histBuilder chan1Inst (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .hit       (hit1),
        .frameEnd  (frameEnd),
        .ts        (ts1),
        .busy      (busy1),
        .accepting (accepting1),
        .peakValid (peakValid1),
        .peak      (peak1)
    );

    peakCombiner combinerInst (
        .clk         (clk),
        .res         (res),
        .peakValid0  (peakValid0),
        .peakValid1  (peakValid1),
        .peak0       (peak0),
        .peak1       (peak1),
        .resultValid (resultValid),
        .result      (result)
    );

    // busy if either channel is, accepting only when both are
    always_comb begin
        status.busy      = busy0 | busy1;
        status.accepting = accepting0 & accepting1;
    end

endmodule

//--- dv/tofHistTb.sv
module tofHistTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod     = 20;
    localparam int resetCycles   = 16;
    localparam int driveDelay    = 2;
    localparam int resultLatency = 20; // frameEnd sampling edge to resultValid
    localparam int resultTimeout = 25;
    localparam int maxRecords    = 64;
    localparam int cyclesPerRec  = 30;

    // record opcodes
    localparam logic [3:0] opIdle     = 4'h0;
    localparam logic [3:0] opStart    = 4'h1;
    localparam logic [3:0] opHit      = 4'h2;
    localparam logic [3:0] opFrameEnd = 4'h3;
    localparam logic [3:0] opExpect   = 4'h4;
    localparam logic [3:0] opEnd      = 4'hF;

    logic clk;
    logic res;
    logic start;
    logic frameEnd;
    logic hit0;
    logic hit1;

    histDataPkg::timeStamp   ts0;
    histDataPkg::timeStamp   ts1;
    logic                    resultValid;
    histDataPkg::frameResult result;
    histCtrlPkg::chanStatus  status;

    logic [47:0] vectors [maxRecords];
    int          numRecords;
    int          limitCycles;
    logic        loaded;
    int          errorCount;
    int          checkCount;

    histDataPkg::frameResult lastResult;  // taken at the resultValid pulse
    int                      lastLatency;

    tofHistTop tofHistTop_inst (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .frameEnd    (frameEnd),
        .hit0        (hit0),
        .hit1        (hit1),
        .ts0         (ts0),
        .ts1         (ts1),
        .resultValid (resultValid),
        .result      (result),
        .status      (status)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkVal(input string name, input logic [31:0] observed,
                            input logic [31:0] expected);
        checkCount++;
        if (observed !== expected) begin
            errorCount++;
            $display("[ERROR] %s observed 0x%0h expected 0x%0h at %0t",
                     name, observed, expected, $time);
        end
    endtask

    // moves to the drive point just after the next rising edge
    task automatic nextCycle();
        @(posedge clk);
        #(driveDelay);
    endtask

    task automatic clearInputs();
        start    = 1'b0;
        frameEnd = 1'b0;
        hit0     = 1'b0;
        hit1     = 1'b0;
        ts0      = '0;
        ts1      = '0;
    endtask

    // one clock of stimulus with no result pulse expected
    task automatic driveCycle(input logic s, input logic fe, input logic h0, input logic h1,
                              input histDataPkg::timeStamp t0, input histDataPkg::timeStamp t1);
        start    = s;
        frameEnd = fe;
        hit0     = h0;
        hit1     = h1;
        ts0      = t0;
        ts1      = t1;
        nextCycle();
        checkVal("resultValid", resultValid, 1'b0);
    endtask

    task automatic awaitResult();
        int waited;
        waited = 1; // frameEnd edge already behind us
        clearInputs();
        while (!resultValid && waited < resultTimeout) begin
            nextCycle();
            waited++;
        end
        if (!resultValid) begin
            errorCount++;
            $display("no result arrived within %0d cycles after frameEnd at %0t",
                     resultTimeout, $time);
        end
        lastResult  = result;
        lastLatency = waited;
    endtask

    task automatic runRecord(input int index, input logic [47:0] rec);
        logic [3:0]  op;
        logic [3:0]  flags;
        logic [11:0] fieldA;
        logic [11:0] fieldB;
        logic [15:0] fieldC;
        op     = rec[47:44];
        flags  = rec[43:40];
        fieldA = rec[39:28];
        fieldB = rec[27:16];
        fieldC = rec[15:0];
        case (op)
            opIdle: begin
                repeat (fieldC) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            end
            opStart: begin
                driveCycle(1'b1, 1'b0, 1'b0, 1'b0, '0, '0);
            end
            opHit: begin
                repeat (fieldC) begin
                    // status now is the state that samples this hit
                    checkVal("status.busy", status.busy, flags[2]);
                    checkVal("status.accepting", status.accepting, flags[3]);
                    driveCycle(1'b0, 1'b0, flags[0], flags[1], fieldA[9:0], fieldB[9:0]);
                end
            end
            opFrameEnd: begin
                driveCycle(1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
                awaitResult();
            end
            opExpect: begin
                checkVal("result.winner", lastResult.winner, flags[0]);
                checkVal("result.peak.bin", lastResult.peak.bin, fieldA);
                checkVal("result.peak.count", lastResult.peak.count, fieldB);
                checkVal("result.delta", {27'b0, lastResult.delta}, {27'b0, fieldC[4:0]});
                checkVal("resultValid latency", lastLatency, resultLatency);
            end
            default: begin
                errorCount++;
                $display("record %0d has an unknown opcode %0h", index, op);
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        res        = 1'b0;
        loaded     = 1'b0;
        errorCount = 0;
        checkCount = 0;
        clearInputs();

        $readmemh("dv/histVectors.mem", vectors);
        numRecords  = 0;
        limitCycles = resetCycles;
        while (numRecords < maxRecords && !$isunknown(vectors[numRecords]) &&
               vectors[numRecords][47:44] != opEnd) begin
            limitCycles += cyclesPerRec;
            if (vectors[numRecords][47:44] == opIdle ||
                vectors[numRecords][47:44] == opHit) begin
                limitCycles += int'(vectors[numRecords][15:0]); // repeated cycles
            end
            numRecords++;
        end
        loaded = 1'b1;
        if (numRecords == 0) begin
            errorCount++;
            $display("no records found in dv/histVectors.mem");
        end

        repeat (resetCycles) @(posedge clk);
        #(driveDelay);
        res = 1'b1;
        checkVal("status", status, 2'b00); // idle after reset

        for (int i = 0; i < numRecords; i++) begin
            runRecord(i, vectors[i]);
        end

        $display("errors %0d, checks %0d", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // budget grows with the record count and the repeated cycles
    initial begin
        wait (loaded === 1'b1);
        #(limitCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, the run did not complete", limitCycles);
        $display("errors %0d, checks %0d", errorCount, checkCount);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/histDataPkg.sv
hw/histCtrlPkg.sv
hw/histRam.sv
hw/histBuilder.sv
hw/peakCombiner.sv
hw/tofHistTop.sv
dv/tofHistTb.sv

//--- Bender.yml
package:
  name: tofHist

sources:
  - include_dirs:
      - hw
    files:
      - hw/histDataPkg.sv
      - hw/histCtrlPkg.sv
      - hw/histRam.sv
      - hw/histBuilder.sv
      - hw/peakCombiner.sv
      - hw/tofHistTop.sv
  - target: test
    files:
      - dv/tofHistTb.sv

//--- dv/histVectors.mem
// one 48-bit record per line: op, flags, field A (3 digits), field B (3), field C (4)
// op 0 idle C cycles, 1 start, 2 hits for C cycles with A ts0 and B ts1, 3 frameEnd, 4 expect, F end
// hit flags: bit0 hit0, bit1 hit1, bit2 busy expected, bit3 accepting expected
// expect: flags winner, A bin, B count, C binDelta in two's complement
// frame 1, chan0 peaks in bin 5, chan1 in bin 9 with more hits
100000000000
000000000010
2B1502600003
000000000003
2A0002450002
290A00000001
300000000000
410090050004
000000000005
// frame 2, 42 back-to-back hits per channel, tie goes to chan0, delay -15
100000000000
000000000010
2B3C0000002A
300000000000
4000F02AFFF1
000000000005
// frame 3, chan1 runs into saturation at 255
100000000000
000000000010
2B1C03FF0064
2A0003FF00C8
300000000000
4100F0FF0008
000000000005
// frame 4, hits during clear are dropped, ties inside each channel keep the lower bin
100000000000
271001000010
2B1803000002
2B0C00400002
300000000000
40003002FFFE
F00000000000
